// ==== project.f ====
common/istream_cfg_pkg.sv
common/istream_types_pkg.sv
istream/istream_ctrl.sv
istream/istream_buffer.sv
istream/istream_extract.sv
istream/istream.sv
src/istream_wrapper.sv
testbench/istream_tb.sv

// ==== Bender.yml ====
package:
  name: istream

sources:
  - common/istream_cfg_pkg.sv
  - common/istream_types_pkg.sv
  - istream/istream_ctrl.sv
  - istream/istream_buffer.sv
  - istream/istream_extract.sv
  - istream/istream.sv
  - src/istream_wrapper.sv
  - target: test
    files:
      - testbench/istream_tb.sv

// ==== testbench/istream_tb.sv ====
// Istream testbench
// Directed tests of the registered wrapper against a parcel stream model

`timescale 1ns/1ps
`default_nettype none

module istream_tb;

	localparam int CLK_PERIOD  = 4;
	// Upper bound of beats per test, summed
	localparam int TOTAL_BEATS = 8 + 16 + 16 + 48 + 40 + 40;
	localparam int KIND_COMP   = 0;
	localparam int KIND_MIX    = 1;
	localparam int KIND_SPAN   = 2;
	localparam int KIND_CLOSE  = 3;
	localparam int BLK_W       = 16 * istream_cfg_pkg::PARCELS_PER_BLOCK;

	logic CLK = 1'b0;
	logic nRST, next_valid_senq, next_stall_sdeq, next_restart;
	istream_types_pkg::parcel_mask_t next_valid_by_parcel_senq;
	istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] next_parcels_senq;
	istream_types_pkg::pc_t next_block_pc_senq;
	logic last_stall_senq, last_valid_sdeq;
	istream_types_pkg::way_mask_t last_valid_by_way_sdeq, last_uncompressed_by_way_sdeq;
	istream_types_pkg::instr_t [istream_cfg_pkg::WAYS-1:0] last_instr_by_way_sdeq;
	istream_types_pkg::pc_t [istream_cfg_pkg::WAYS-1:0] last_pc_by_way_sdeq;

	// Blocks not yet sent, open parcels and the expected instruction stream
	istream_types_pkg::parcel_mask_t send_mask[$];
	logic [BLK_W-1:0] send_parcels[$];
	istream_types_pkg::pc_t send_pc[$];
	istream_types_pkg::parcel_t pend_parcel[$];
	istream_types_pkg::pc_t pend_pc[$];
	istream_types_pkg::instr_t exp_instr[$];
	istream_types_pkg::pc_t exp_pc[$];
	logic exp_unc[$];

	logic [31:0] lfsr = 32'h574d_ce94;
	// Bit 0 holds last cycle's stall drive and bit 1 the one before
	logic [1:0] stall_hist = 2'b00;
	int stall_mode = 0;
	logic pairs_only = 1'b0;
	logic restart_req = 1'b0;
	logic saw_stall = 1'b0;

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	istream_wrapper dut (
		.CLK, .nRST, .next_valid_senq, .next_valid_by_parcel_senq, .next_parcels_senq,
		.next_block_pc_senq, .next_stall_sdeq, .next_restart, .last_stall_senq,
		.last_valid_sdeq, .last_valid_by_way_sdeq, .last_uncompressed_by_way_sdeq,
		.last_instr_by_way_sdeq, .last_pc_by_way_sdeq
	);

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic compare_instr(input string name, input istream_types_pkg::instr_t got,
			input istream_types_pkg::instr_t exp);
		if (got !== exp)
			stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic compare_pc(input string name, input istream_types_pkg::pc_t got,
			input istream_types_pkg::pc_t exp);
		if (got !== exp)
			stop_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic compare_mask(input string name, input istream_types_pkg::way_mask_t got,
			input istream_types_pkg::way_mask_t exp);
		if (got !== exp)
			stop_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// Low bits 2'b11 open a 32-bit instruction and its next parcel closes it
	task automatic model_push(input istream_types_pkg::parcel_t p,
			input istream_types_pkg::pc_t pc);
		pend_parcel.push_back(p);
		pend_pc.push_back(pc);
		if (pend_parcel.size() == 2) begin
			exp_instr.push_back({pend_parcel[1], pend_parcel[0]});
			exp_pc.push_back(pend_pc[0]);
			exp_unc.push_back(1'b1);
		end else if (p[1:0] != 2'b11) begin
			exp_instr.push_back({16'h0000, p});
			exp_pc.push_back(pc);
			exp_unc.push_back(1'b0);
		end
		if (pend_parcel.size() == 2 || p[1:0] != 2'b11) begin
			pend_parcel.delete();
			pend_pc.delete();
		end
	endtask

	task automatic queue_block(input istream_types_pkg::parcel_mask_t mask,
			input istream_types_pkg::pc_t pc, input int kind);
		logic [BLK_W-1:0] blk;
		logic [31:0] r;
		logic unc;
		blk = '0;
		for (int i = 0; i < istream_cfg_pkg::PARCELS_PER_BLOCK; i++) begin
			if (mask[i]) begin
				r = lfsr_bits(17);
				// High halves stay fully random
				if (pend_parcel.size() == 0) begin
					unc = (kind != KIND_COMP) && r[16];
					if (i == 2 && kind == KIND_SPAN)
						unc = 1'b0;
					if (i == 3)
						unc = (kind == KIND_SPAN) || (unc && kind == KIND_MIX);
					r[1:0] = unc ? 2'b11 : ((r[1:0] == 2'b11) ? 2'b01 : r[1:0]);
				end
				blk[16*i +: 16] = r[15:0];
				model_push(r[15:0], pc + istream_types_pkg::pc_t'(2 * i));
			end
		end
		send_mask.push_back(mask);
		send_parcels.push_back(blk);
		send_pc.push_back(pc);
	endtask

	// Only beats whose stall was driven low two cycles back were consumed
	task automatic check_beat;
		istream_types_pkg::instr_t e_instr;
		istream_types_pkg::pc_t e_pc;
		istream_types_pkg::way_mask_t unc_mask;
		if (last_valid_by_way_sdeq === 2'b10)
			stop_run("way 1 is valid without way 0");
		if (last_valid_sdeq && !stall_hist[1]) begin
			if (last_valid_by_way_sdeq[0] !== 1'b1)
				stop_run("dequeue beat is marked valid without a valid way 0");
			if (pairs_only)
				compare_mask("last_valid_by_way_sdeq", last_valid_by_way_sdeq, 2'b11);
			unc_mask = '0;
			for (int w = 0; w < istream_cfg_pkg::WAYS; w++) begin
				if (last_valid_by_way_sdeq[w]) begin
					if (exp_instr.size() == 0)
						stop_run("DUT delivered an instruction when none was expected");
					e_instr     = exp_instr.pop_front();
					e_pc        = exp_pc.pop_front();
					unc_mask[w] = exp_unc.pop_front();
					compare_instr($sformatf("last_instr_by_way_sdeq[%0d]", w),
						last_instr_by_way_sdeq[w], e_instr);
					compare_pc($sformatf("last_pc_by_way_sdeq[%0d]", w),
						last_pc_by_way_sdeq[w], e_pc);
				end
			end
			compare_mask("last_uncompressed_by_way_sdeq", last_uncompressed_by_way_sdeq,
				unc_mask);
		end
	endtask

	// Check outputs once per clock before driving the next inputs
	task automatic step;
		logic [31:0] r;
		logic stall_now;
		@(posedge CLK);
		#1;
		check_beat();
		if (last_stall_senq)
			saw_stall = 1'b1;
		if (send_mask.size() != 0 && !last_stall_senq && !restart_req) begin
			next_valid_senq           = 1'b1;
			next_valid_by_parcel_senq = send_mask.pop_front();
			next_parcels_senq         = send_parcels.pop_front();
			next_block_pc_senq        = send_pc.pop_front();
		end else begin
			next_valid_senq = 1'b0;
		end
		next_restart = restart_req;
		restart_req  = 1'b0;
		if (stall_mode == 2) begin
			r         = lfsr_bits(1);
			stall_now = r[0];
		end else begin
			stall_now = (stall_mode == 1) || next_restart;
		end
		next_stall_sdeq = stall_now;
		stall_hist      = {stall_hist[0], stall_now};
	endtask

	task automatic drain;
		while (exp_instr.size() != 0 || send_mask.size() != 0)
			step();
		// Any extra beat here has no expected instruction left
		repeat (8) step();
	endtask

	// ------------------------------------------------------------------
	// Tests

	task automatic compressed_stream;
		stall_mode = 0;
		pairs_only = 1'b1;
		for (int b = 0; b < 4; b++)
			queue_block(4'b1111, 32'h0000_1000 + 8 * b, KIND_COMP);
		drain();
		pairs_only = 1'b0;
	endtask

	task automatic mixed_stream;
		stall_mode = 0;
		queue_block(4'b1111, 32'h0000_2000, KIND_SPAN);
		queue_block(4'b1111, 32'h0000_2008, KIND_MIX);
		queue_block(4'b1111, 32'h0000_2010, KIND_SPAN);
		queue_block(4'b1111, 32'h0000_2018, KIND_CLOSE);
		drain();
	endtask

	task automatic offset_start;
		stall_mode = 0;
		queue_block(4'b1100, 32'h0000_3000, KIND_CLOSE);
		queue_block(4'b1110, 32'h0000_3100, KIND_CLOSE);
		queue_block(4'b1111, 32'h0000_3200, KIND_SPAN);
		queue_block(4'b1111, 32'h0000_3208, KIND_CLOSE);
		drain();
	endtask

	task automatic enqueue_backpressure;
		stall_mode = 1;
		saw_stall  = 1'b0;
		for (int b = 0; b < 12; b++)
			queue_block(4'b1111, 32'h0000_4000 + 8 * b, (b == 11) ? KIND_CLOSE : KIND_MIX);
		repeat (40) step();
		if (!saw_stall)
			stop_run("enqueue stall never rose while dequeue was held");
		if (send_mask.size() == 0)
			stop_run("sender was never held back by the enqueue stall");
		stall_mode = 0;
		drain();
	endtask

	task automatic dequeue_backpressure;
		stall_mode = 2;
		for (int b = 0; b < 10; b++)
			queue_block(4'b1111, 32'h0000_5000 + 8 * b, (b == 9) ? KIND_CLOSE : KIND_MIX);
		drain();
	endtask

	task automatic restart_flush;
		stall_mode = 1;
		for (int b = 0; b < 7; b++)
			queue_block(4'b1111, 32'h0000_6000 + 8 * b, KIND_MIX);
		repeat (14) step();
		if (!last_stall_senq)
			stop_run("enqueue stall did not rise with the buffer nearly full");
		restart_req = 1'b1;
		step();
		// Old stream is gone from the model too
		exp_instr.delete();
		exp_pc.delete();
		exp_unc.delete();
		pend_parcel.delete();
		pend_pc.delete();
		repeat (4) step();
		if (last_valid_sdeq || last_stall_senq)
			stop_run("buffer still shows old blocks or stall after restart");
		stall_mode = 0;
		queue_block(4'b1111, 32'h0000_7000, KIND_MIX);
		queue_block(4'b1111, 32'h0000_7008, KIND_MIX);
		queue_block(4'b1111, 32'h0000_7010, KIND_CLOSE);
		drain();
	endtask

	initial begin
		#(TOTAL_BEATS * 20 * CLK_PERIOD);
		stop_run("timeout: the run did not finish in the expected number of cycles");
	end

	initial begin
		nRST                      = 1'b0;
		next_valid_senq           = 1'b0;
		next_valid_by_parcel_senq = '0;
		next_parcels_senq         = '0;
		next_block_pc_senq        = '0;
		next_stall_sdeq           = 1'b0;
		next_restart              = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		nRST = 1'b1;
		// Outputs come out of reset idle
		if (last_valid_sdeq || last_stall_senq)
			stop_run("dequeue valid or enqueue stall is high after reset");
		compare_mask("last_valid_by_way_sdeq", last_valid_by_way_sdeq, 2'b00);
		compressed_stream();
		mixed_stream();
		offset_start();
		enqueue_backpressure();
		dequeue_backpressure();
		restart_flush();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/istream_wrapper.sv ====
// Istream top level
// Registers every port once around the core buffer

`timescale 1ns/1ps
`default_nettype none

module istream_wrapper (
	input  logic                            CLK,
	input  logic                            nRST,
	input  logic                            next_valid_senq,
	input  istream_types_pkg::parcel_mask_t next_valid_by_parcel_senq,
	input  istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0]
		next_parcels_senq,
	input  istream_types_pkg::pc_t          next_block_pc_senq,
	input  logic                            next_stall_sdeq,
	input  logic                            next_restart,
	output logic                            last_stall_senq,
	output logic                            last_valid_sdeq,
	output istream_types_pkg::way_mask_t    last_valid_by_way_sdeq,
	output istream_types_pkg::way_mask_t    last_uncompressed_by_way_sdeq,
	output istream_types_pkg::instr_t [istream_cfg_pkg::WAYS-1:0] last_instr_by_way_sdeq,
	output istream_types_pkg::pc_t [istream_cfg_pkg::WAYS-1:0]    last_pc_by_way_sdeq
);

	// ------------------------------------------------------------------
	// Core side signals

	logic valid_senq, stall_senq, valid_sdeq, stall_sdeq, restart;
	istream_types_pkg::parcel_mask_t valid_by_parcel_senq;
	istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] parcels_senq;
	istream_types_pkg::pc_t block_pc_senq;
	istream_types_pkg::way_mask_t valid_by_way_sdeq, uncompressed_by_way_sdeq;
	istream_types_pkg::instr_t [istream_cfg_pkg::WAYS-1:0] instr_by_way_sdeq;
	istream_types_pkg::pc_t [istream_cfg_pkg::WAYS-1:0] pc_by_way_sdeq;

	istream core (.*);

	// ------------------------------------------------------------------
	// Boundary registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_senq                    <= 1'b0;
			valid_by_parcel_senq          <= '0;
			parcels_senq                  <= '0;
			block_pc_senq                 <= '0;
			stall_sdeq                    <= 1'b0;
			restart                       <= 1'b0;
			last_stall_senq               <= 1'b0;
			last_valid_sdeq               <= 1'b0;
			last_valid_by_way_sdeq        <= '0;
			last_uncompressed_by_way_sdeq <= '0;
			last_instr_by_way_sdeq        <= '0;
			last_pc_by_way_sdeq           <= '0;
		end else begin
			// Inputs toward the core
			valid_senq                    <= next_valid_senq;
			valid_by_parcel_senq          <= next_valid_by_parcel_senq;
			parcels_senq                  <= next_parcels_senq;
			block_pc_senq                 <= next_block_pc_senq;
			stall_sdeq                    <= next_stall_sdeq;
			restart                       <= next_restart;
			// Outputs from the core
			last_stall_senq               <= stall_senq;
			last_valid_sdeq               <= valid_sdeq;
			last_valid_by_way_sdeq        <= valid_by_way_sdeq;
			last_uncompressed_by_way_sdeq <= uncompressed_by_way_sdeq;
			last_instr_by_way_sdeq        <= instr_by_way_sdeq;
			last_pc_by_way_sdeq           <= pc_by_way_sdeq;
		end
	end

endmodule

`default_nettype wire

// ==== istream/istream.sv ====
// Istream core
// Joins control, block storage and instruction alignment

`timescale 1ns/1ps
`default_nettype none

module istream (
	input  logic                            CLK,
	input  logic                            nRST,
	input  logic                            valid_senq,
	input  istream_types_pkg::parcel_mask_t valid_by_parcel_senq,
	input  istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] parcels_senq,
	input  istream_types_pkg::pc_t          block_pc_senq,
	output logic                            stall_senq,
	output logic                            valid_sdeq,
	output istream_types_pkg::way_mask_t    valid_by_way_sdeq,
	output istream_types_pkg::way_mask_t    uncompressed_by_way_sdeq,
	output istream_types_pkg::instr_t [istream_cfg_pkg::WAYS-1:0] instr_by_way_sdeq,
	output istream_types_pkg::pc_t [istream_cfg_pkg::WAYS-1:0]    pc_by_way_sdeq,
	input  logic                            stall_sdeq,
	input  logic                            restart
);

	logic wr_en, valid_sdeq_gate, head_present, next_present;
	logic [1:0] entries_beyond_head;
	logic [2:0] consumed_parcels;
	istream_types_pkg::blk_idx_t wr_idx, head_idx, next_idx;
	istream_types_pkg::parcel_idx_t head_ptr;
	istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] head_parcels;
	istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] next_parcels;
	istream_types_pkg::parcel_mask_t head_mask, next_mask;
	istream_types_pkg::pc_t head_pc, next_pc;

	istream_ctrl ctrl (
		.CLK, .nRST, .valid_senq, .restart, .stall_sdeq,
		.valid_by_parcel_head(head_mask), .consumed_parcels,
		.stall_senq, .wr_en, .wr_idx, .head_idx, .next_idx, .head_ptr,
		.entries_beyond_head, .valid_sdeq_gate
	);

	istream_buffer buffer (
		.CLK, .nRST, .wr_en, .wr_idx, .wr_parcels(parcels_senq),
		.wr_mask(valid_by_parcel_senq), .wr_pc(block_pc_senq), .head_idx, .next_idx,
		.head_parcels, .head_mask, .head_pc, .next_parcels, .next_mask, .next_pc
	);

	// Spanning only into a block that starts at parcel 0
	assign head_present = (entries_beyond_head != 2'd0);
	assign next_present = (entries_beyond_head >= 2'd2) && next_mask[0];

	istream_extract extract (
		.head_parcels, .head_pc, .next_parcels, .next_pc, .head_ptr,
		.head_present, .next_present, .valid_sdeq_gate,
		.valid_sdeq, .valid_by_way_sdeq, .uncompressed_by_way_sdeq,
		.instr_by_way_sdeq, .pc_by_way_sdeq, .consumed_parcels
	);

endmodule

`default_nettype wire

// ==== istream/istream_extract.sv ====
// Istream alignment
// Walks a two-block parcel window and forms up to WAYS instructions

`timescale 1ns/1ps
`default_nettype none

module istream_extract (
	input  istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] head_parcels,
	input  istream_types_pkg::pc_t          head_pc,
	input  istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] next_parcels,
	input  istream_types_pkg::pc_t          next_pc,
	input  istream_types_pkg::parcel_idx_t  head_ptr,
	input  logic                            head_present,
	input  logic                            next_present,
	input  logic                            valid_sdeq_gate,
	output logic                            valid_sdeq,
	output istream_types_pkg::way_mask_t    valid_by_way_sdeq,
	output istream_types_pkg::way_mask_t    uncompressed_by_way_sdeq,
	output istream_types_pkg::instr_t [istream_cfg_pkg::WAYS-1:0] instr_by_way_sdeq,
	output istream_types_pkg::pc_t [istream_cfg_pkg::WAYS-1:0]    pc_by_way_sdeq,
	output logic [2:0]                      consumed_parcels
);

	istream_types_pkg::parcel_t [istream_cfg_pkg::WINDOW_PARCELS-1:0] window;
	logic [istream_cfg_pkg::WINDOW_PARCELS-1:0] present;

	assign window = {next_parcels, head_parcels};

	// Head parcels below the pointer are already consumed
	always_comb begin
		for (int i = 0; i < istream_cfg_pkg::PARCELS_PER_BLOCK; i++) begin
			present[i] = head_present && (i >= int'(head_ptr));
			present[i + istream_cfg_pkg::PARCELS_PER_BLOCK] = next_present;
		end
	end

	always_comb begin : walk
		logic [istream_cfg_pkg::WINDOW_IDX_W-1:0] ptr;
		logic [istream_cfg_pkg::WINDOW_IDX_W-1:0] ptr_hi;
		logic compressed;
		logic ok;
		logic [2:0] used;
		ptr  = istream_cfg_pkg::WINDOW_IDX_W'(head_ptr);
		ok   = valid_sdeq_gate;
		used = '0;
		for (int w = 0; w < istream_cfg_pkg::WAYS; w++) begin
			ptr_hi     = ptr + 1'b1;
			// Low bits 2'b11 mark a 32-bit instruction
			compressed = (window[ptr][1:0] != 2'b11);
			ok         = ok && present[ptr] && (compressed || present[ptr_hi]);
			valid_by_way_sdeq[w]        = ok;
			uncompressed_by_way_sdeq[w] = ok && !compressed;
			instr_by_way_sdeq[w] = compressed ? {16'h0000, window[ptr]}
				: {window[ptr_hi], window[ptr]};
			pc_by_way_sdeq[w] = (ptr[istream_cfg_pkg::PARCEL_IDX_W] ? next_pc : head_pc)
				+ istream_types_pkg::pc_t'({ptr[istream_cfg_pkg::PARCEL_IDX_W-1:0], 1'b0});
			if (ok) begin
				used = used + (compressed ? 3'd1 : 3'd2);
				ptr  = compressed ? ptr_hi : ptr + 2'd2;
			end
		end
		consumed_parcels = used;
	end

	// Way 1 never valid without way 0
	assign valid_sdeq = valid_by_way_sdeq[0];

endmodule

`default_nettype wire

// ==== istream/istream_buffer.sv ====
// Istream block storage
// Fetch block array with one write port and head and next read ports

`timescale 1ns/1ps
`default_nettype none

module istream_buffer (
	input  logic                           CLK,
	input  logic                           nRST,
	input  logic                           wr_en,
	input  istream_types_pkg::blk_idx_t    wr_idx,
	input  istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] wr_parcels,
	input  istream_types_pkg::parcel_mask_t wr_mask,
	input  istream_types_pkg::pc_t         wr_pc,
	input  istream_types_pkg::blk_idx_t    head_idx,
	input  istream_types_pkg::blk_idx_t    next_idx,
	output istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] head_parcels,
	output istream_types_pkg::parcel_mask_t head_mask,
	output istream_types_pkg::pc_t         head_pc,
	output istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] next_parcels,
	output istream_types_pkg::parcel_mask_t next_mask,
	output istream_types_pkg::pc_t         next_pc
);

	// ------------------------------------------------------------------
	// Storage

	istream_types_pkg::parcel_t [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0]
		parcels_mem [istream_cfg_pkg::ISTREAM_DEPTH];
	istream_types_pkg::parcel_mask_t mask_mem [istream_cfg_pkg::ISTREAM_DEPTH];
	istream_types_pkg::pc_t          pc_mem   [istream_cfg_pkg::ISTREAM_DEPTH];

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			parcels_mem[wr_idx] <= wr_parcels;
			mask_mem[wr_idx]    <= wr_mask;
			pc_mem[wr_idx]      <= wr_pc;
		end
	end

	// ------------------------------------------------------------------
	// Head and next read ports so one instruction can span two blocks

	assign head_parcels = parcels_mem[head_idx];
	assign head_mask    = mask_mem[head_idx];
	assign head_pc      = pc_mem[head_idx];
	assign next_parcels = parcels_mem[next_idx];
	assign next_mask    = mask_mem[next_idx];
	assign next_pc      = pc_mem[next_idx];

	// Sender masks are nonzero and run up to parcel 3
	assert property (@(posedge CLK) disable iff (!nRST)
		wr_en |-> (wr_mask != '0) &&
			((wr_mask | istream_types_pkg::parcel_mask_t'(wr_mask << 1)) == wr_mask));

endmodule

`default_nettype wire

// ==== istream/istream_ctrl.sv ====
// Istream control
// Block pointers, occupancy, parcel pointer, enqueue stall and restart flush

`timescale 1ns/1ps
`default_nettype none

module istream_ctrl (
	input  logic                           CLK,
	input  logic                           nRST,
	input  logic                           valid_senq,
	input  logic                           restart,
	input  logic                           stall_sdeq,
	input  istream_types_pkg::parcel_mask_t valid_by_parcel_head,
	input  logic [2:0]                     consumed_parcels,
	output logic                           stall_senq,
	output logic                           wr_en,
	output istream_types_pkg::blk_idx_t    wr_idx,
	output istream_types_pkg::blk_idx_t    head_idx,
	output istream_types_pkg::blk_idx_t    next_idx,
	output istream_types_pkg::parcel_idx_t head_ptr,
	output logic [1:0]                     entries_beyond_head,
	output logic                           valid_sdeq_gate
);

	istream_types_pkg::ctrl_state_t state, state_next;
	istream_types_pkg::blk_idx_t head, tail;
	istream_types_pkg::parcel_idx_t ptr_q, first_valid;
	logic [istream_cfg_pkg::COUNT_W-1:0] count, count_next;
	logic [2:0] ptr_sum;
	logic deq, pop;

	// Lowest set mask bit of the head block
	always_comb begin
		first_valid = '0;
		for (int i = istream_cfg_pkg::PARCELS_PER_BLOCK - 1; i >= 0; i--) begin
			if (valid_by_parcel_head[i]) begin
				first_valid = istream_types_pkg::parcel_idx_t'(i);
			end
		end
	end

	// A fresh head block starts at its first valid parcel
	assign head_ptr = (ptr_q > first_valid) ? ptr_q : first_valid;

	assign deq     = ~restart & ~stall_sdeq & (consumed_parcels != '0);
	assign ptr_sum = {1'b0, head_ptr} + consumed_parcels;
	// Pointer ran past parcel 3
	assign pop     = deq & ptr_sum[2];
	assign wr_en   = valid_senq & ~restart;

	assign count_next = count + istream_cfg_pkg::COUNT_W'(wr_en)
		- istream_cfg_pkg::COUNT_W'(pop);

	always_comb begin
		state_next = state;
		case (state)
			istream_types_pkg::EMPTY, istream_types_pkg::FLUSH: begin
				state_next = wr_en ? istream_types_pkg::STREAMING : istream_types_pkg::EMPTY;
			end
			istream_types_pkg::STREAMING: begin
				if (count_next == '0) begin
					state_next = istream_types_pkg::EMPTY;
				end
			end
			default: state_next = istream_types_pkg::EMPTY;
		endcase
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= istream_types_pkg::EMPTY;
			head  <= '0;
			tail  <= '0;
			count <= '0;
			ptr_q <= '0;
		end else if (restart) begin
			state <= istream_types_pkg::FLUSH;
			head  <= '0;
			tail  <= '0;
			count <= '0;
			ptr_q <= '0;
		end else begin
			state <= state_next;
			count <= count_next;
			if (wr_en) begin
				tail <= tail + 1'b1;
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			if (deq) begin
				ptr_q <= ptr_sum[1:0];
			end
		end
	end

	assign wr_idx          = tail;
	assign head_idx        = head;
	assign next_idx        = head + 1'b1;
	assign valid_sdeq_gate = (state == istream_types_pkg::STREAMING);
	assign entries_beyond_head = (count > 3) ? 2'd3 : count[1:0];
	// Keep room for the beats already in the wrapper registers
	assign stall_senq = count >= istream_cfg_pkg::COUNT_W'(
		istream_cfg_pkg::ISTREAM_DEPTH - istream_cfg_pkg::SKID_ENTRIES);

	// Skid reserve must absorb every beat the sender had in flight
	assert property (@(posedge CLK) disable iff (!nRST)
		wr_en |-> count < istream_cfg_pkg::COUNT_W'(istream_cfg_pkg::ISTREAM_DEPTH));

	// No consumption from an empty buffer
	assert property (@(posedge CLK) disable iff (!nRST)
		deq |-> count != '0);

endmodule

`default_nettype wire

// ==== common/istream_types_pkg.sv ====
// Istream types
// Plain vector typedefs for parcels, instructions, PCs and indices

`default_nettype none

package istream_types_pkg;

	// One 16-bit instruction parcel
	typedef logic [15:0] parcel_t;

	// Compressed instructions sit in the low half, high half zero
	typedef logic [31:0] instr_t;

	// Byte address
	typedef logic [31:0] pc_t;

	// One bit per parcel of a fetch block
	typedef logic [istream_cfg_pkg::PARCELS_PER_BLOCK-1:0] parcel_mask_t;

	// Parcel position inside a block
	typedef logic [istream_cfg_pkg::PARCEL_IDX_W-1:0] parcel_idx_t;

	// One bit per dequeue way
	typedef logic [istream_cfg_pkg::WAYS-1:0] way_mask_t;

	// Buffer entry index
	typedef logic [istream_cfg_pkg::BLK_IDX_W-1:0] blk_idx_t;

	// Control FSM
	typedef enum logic [1:0] {
		EMPTY,
		STREAMING,
		FLUSH
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== common/istream_cfg_pkg.sv ====
// Istream configuration
// Sizes of the fetch block stream and of the instruction buffer

`default_nettype none

package istream_cfg_pkg;

	// Fetch block shape
	localparam int PARCELS_PER_BLOCK = 4;
	localparam int PARCEL_IDX_W      = $clog2(PARCELS_PER_BLOCK);
	localparam int WINDOW_PARCELS    = 2 * PARCELS_PER_BLOCK;
	localparam int WINDOW_IDX_W      = $clog2(WINDOW_PARCELS);

	// Dequeue width and buffer sizing
	localparam int WAYS          = 2;
	localparam int ISTREAM_DEPTH = 8;
	localparam int BLK_IDX_W     = $clog2(ISTREAM_DEPTH);
	localparam int COUNT_W       = $clog2(ISTREAM_DEPTH + 1);
	// Covers the two beats in flight through the wrapper
	localparam int SKID_ENTRIES  = 2;

endpackage

`default_nettype wire
